// File: dma_cfg_pkg.sv
`default_nettype none

package dma_cfg_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths and register map
  //////////////////////////////////////////////////////////////////////

  localparam int lite_addr_w = 32;  // axi-lite address
  localparam int lite_data_w = 32;  // axi-lite data

  localparam int dma_chan_n = 4;  // h2c/c2h channel pairs in the engine
  localparam int boot_steps = 8;  // one run-bit write per channel and direction

  localparam logic [7:0] ctrl_offset = 8'h04;  // channel control reg
  localparam logic [lite_data_w-1:0] run_bit = 32'h0000_0001;

  localparam logic [3:0] dir_h2c = 4'd0;
  localparam logic [3:0] dir_c2h = 4'd1;

  localparam logic [1:0] resp_okay = 2'b00;

  // boot sequencer states, one-hot
  localparam logic [3:0] boot_st_idle = 4'b0001;
  localparam logic [3:0] boot_st_addr = 4'b0010;
  localparam logic [3:0] boot_st_data = 4'b0100;
  localparam logic [3:0] boot_st_done = 4'b1000;

  //////////////////////////////////////////////////////////////////////
  // register address, raw word or decoded fields
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [15:0] rsvd;    // upper half unused by the engine
    logic [3:0]  dir;     // 0 = h2c, 1 = c2h
    logic [3:0]  chan;    // channel index
    logic [7:0]  offset;  // reg offset within the channel block
  } dma_reg_fld_t;

  typedef union packed {
    logic [lite_addr_w-1:0] raw;
    dma_reg_fld_t           fld;
  } dma_reg_addr_u;

  //////////////////////////////////////////////////////////////////////
  // axi-lite channel bundles
  //////////////////////////////////////////////////////////////////////

  // master -> target, write side
  typedef struct packed {
    logic                   awvalid;
    dma_reg_addr_u          awaddr;
    logic                   wvalid;
    logic [lite_data_w-1:0] wdata;
  } lite_wr_req_t;

  // master -> target, read address
  typedef struct packed {
    logic          arvalid;
    dma_reg_addr_u araddr;
  } lite_rd_req_t;

  // target -> master, everything coming back
  typedef struct packed {
    logic                   awready;
    logic                   wready;
    logic                   bvalid;
    logic [1:0]             bresp;
    logic                   arready;
    logic                   rvalid;
    logic [lite_data_w-1:0] rdata;
    logic [1:0]             rresp;
  } lite_rsp_t;

  // host command bits, rising edge = one access
  typedef struct packed {
    logic wr;
    logic rd;
  } host_cmd_t;

endpackage

`default_nettype wire

// File: dma_boot_seq.sv
`timescale 1ns/10ps
`default_nettype none

module dma_boot_seq (
  input  wire                      pcie_clk,
  input  wire                      pcie_aresetn,
  input  wire dma_cfg_pkg::lite_rsp_t rsp,
  output dma_cfg_pkg::lite_wr_req_t   boot_wr,
  output logic                     boot_done
);

  logic [3:0] state;  // one-hot
  logic [$clog2(dma_cfg_pkg::boot_steps)-1:0] step;  // which run bit is being written
  dma_cfg_pkg::dma_reg_addr_u boot_addr;

  logic aw_hs;
  logic w_hs;
  logic last_step;

  //////////////////////////////////////////////////////////////////////
  // handshakes
  //////////////////////////////////////////////////////////////////////

  assign aw_hs = state[1] & rsp.awready;  // ADDR drives awvalid
  assign w_hs  = state[2] & rsp.wready;   // DATA drives wvalid
  assign last_step = (step == dma_cfg_pkg::boot_steps - 1);

  //////////////////////////////////////////////////////////////////////
  // address of the current step
  //////////////////////////////////////////////////////////////////////

  // step k -> channel (k/2+1) mod 4, so channel 0 comes last
  always_comb begin
    boot_addr.raw        = '0;
    boot_addr.fld.offset = dma_cfg_pkg::ctrl_offset;
    boot_addr.fld.chan   = 4'(((int'(step) >> 1) + 1) % dma_cfg_pkg::dma_chan_n);
    boot_addr.fld.dir    = step[0] ? dma_cfg_pkg::dir_c2h : dma_cfg_pkg::dir_h2c;
  end

  //////////////////////////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      state <= dma_cfg_pkg::boot_st_idle;
      step  <= '0;
    end else begin
      case (state)
        dma_cfg_pkg::boot_st_idle: begin
          state <= dma_cfg_pkg::boot_st_addr;  // one idle cycle per step
        end
        dma_cfg_pkg::boot_st_addr: begin
          if (aw_hs) begin
            state <= dma_cfg_pkg::boot_st_data;  // wvalid the cycle after
          end
        end
        dma_cfg_pkg::boot_st_data: begin
          if (w_hs) begin
            step <= step + 1'b1;
            // jump straight to done so boot_done follows the last w beat
            if (last_step) begin
              state <= dma_cfg_pkg::boot_st_done;
            end else begin
              state <= dma_cfg_pkg::boot_st_idle;
            end
          end
        end
        dma_cfg_pkg::boot_st_done: begin
          state <= dma_cfg_pkg::boot_st_done;  // park here until reset
        end
        default: begin
          state <= dma_cfg_pkg::boot_st_idle;  // bad one-hot, restart
          step  <= '0;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////////////////////////

  assign boot_wr.awvalid = state[1];
  assign boot_wr.awaddr  = boot_addr;
  assign boot_wr.wvalid  = state[2];
  assign boot_wr.wdata   = dma_cfg_pkg::run_bit;  // every control write starts the channel

  assign boot_done = state[3];

endmodule

`default_nettype wire

// File: dma_host_access.sv
`timescale 1ns/10ps
`default_nettype none

module dma_host_access (
  input  wire                        pcie_clk,
  input  wire                        pcie_aresetn,
  input  wire dma_cfg_pkg::host_cmd_t host_cmd,
  input  wire [31:0]                 host_awaddr,
  input  wire [31:0]                 host_wdata,
  input  wire [31:0]                 host_araddr,
  input  wire                        boot_done,
  input  wire dma_cfg_pkg::lite_rsp_t rsp,
  output dma_cfg_pkg::lite_wr_req_t  host_wr,
  output dma_cfg_pkg::lite_rd_req_t  host_rd
);

  dma_cfg_pkg::host_cmd_t cmd_r;   // first sample
  dma_cfg_pkg::host_cmd_t cmd_rr;  // previous sample, for edges

  logic wr_rise;
  logic rd_rise;

  logic aw_pend;  // write address waiting for handshake
  logic w_pend;   // write data waiting for handshake
  logic ar_pend;  // read address waiting for handshake

  logic [31:0] wr_addr_q;
  logic [31:0] wr_data_q;
  logic [31:0] rd_addr_q;

  logic aw_hs;
  logic w_hs;
  logic ar_hs;

  //////////////////////////////////////////////////////////////////////
  // command edge detect
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      cmd_r  <= '0;
      cmd_rr <= '0;
    end else begin
      cmd_r  <= host_cmd;
      cmd_rr <= cmd_r;
    end
  end

  assign wr_rise = cmd_r.wr & ~cmd_rr.wr;
  assign rd_rise = cmd_r.rd & ~cmd_rr.rd;

  //////////////////////////////////////////////////////////////////////
  // write path, aw then w
  //////////////////////////////////////////////////////////////////////

  assign aw_hs = host_wr.awvalid & rsp.awready;
  assign w_hs  = host_wr.wvalid & rsp.wready;

  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      aw_pend <= 1'b0;
      w_pend  <= 1'b0;
    end else begin
      if (wr_rise && !aw_pend && !w_pend) begin
        aw_pend <= 1'b1;  // edge while busy is dropped
      end else if (aw_hs) begin
        aw_pend <= 1'b0;
      end
      if (aw_hs) begin
        w_pend <= 1'b1;  // data one cycle behind the address
      end else if (w_hs) begin
        w_pend <= 1'b0;
      end
    end
  end

  // capture host values at the edge, held under back-pressure
  always_ff @(posedge pcie_clk) begin
    if (wr_rise && !aw_pend && !w_pend) begin
      wr_addr_q <= host_awaddr;
      wr_data_q <= host_wdata;
    end
  end

  assign host_wr.awvalid    = aw_pend & boot_done;  // sequencer owns the bus during boot
  assign host_wr.awaddr.raw = wr_addr_q;
  assign host_wr.wvalid     = w_pend;
  assign host_wr.wdata      = wr_data_q;

  //////////////////////////////////////////////////////////////////////
  // read path
  //////////////////////////////////////////////////////////////////////

  assign ar_hs = host_rd.arvalid & rsp.arready;

  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      ar_pend <= 1'b0;
    end else if (rd_rise && !ar_pend) begin
      ar_pend <= 1'b1;  // reads allowed during boot too
    end else if (ar_hs) begin
      ar_pend <= 1'b0;
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (rd_rise && !ar_pend) begin
      rd_addr_q <= host_araddr;
    end
  end

  assign host_rd.arvalid    = ar_pend;
  assign host_rd.araddr.raw = rd_addr_q;

endmodule

`default_nettype wire

// File: dma_lite_merge.sv
`timescale 1ns/10ps
`default_nettype none

module dma_lite_merge (
  input  wire                          pcie_clk,
  input  wire                          pcie_aresetn,
  input  wire                          boot_done,
  input  wire dma_cfg_pkg::lite_wr_req_t boot_wr,
  input  wire dma_cfg_pkg::lite_wr_req_t host_wr,
  input  wire dma_cfg_pkg::lite_rd_req_t host_rd,
  input  wire dma_cfg_pkg::lite_rsp_t    rsp,
  output dma_cfg_pkg::lite_wr_req_t    wr_req,
  output dma_cfg_pkg::lite_rd_req_t    rd_req,
  output logic                         bready,
  output logic                         rready,
  output logic [31:0]                  rd_data,
  output logic                         rd_done,
  output logic                         resp_error
);

  logic rsp_rdy;  // response channels always accepted once running
  logic b_hs;
  logic r_hs;
  logic b_bad;
  logic r_bad;

  //////////////////////////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////////////////////////

  // write channels switch owner once, when boot finishes
  assign wr_req = boot_done ? host_wr : boot_wr;
  assign rd_req = host_rd;  // host only reader

  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      rsp_rdy <= 1'b0;
    end else begin
      rsp_rdy <= 1'b1;
    end
  end

  assign bready = rsp_rdy;
  assign rready = rsp_rdy;

  //////////////////////////////////////////////////////////////////////
  // response side
  //////////////////////////////////////////////////////////////////////

  assign b_hs  = rsp.bvalid & bready;
  assign r_hs  = rsp.rvalid & rready;
  assign b_bad = b_hs & (rsp.bresp != dma_cfg_pkg::resp_okay);
  assign r_bad = r_hs & (rsp.rresp != dma_cfg_pkg::resp_okay);

  // read data word, updated only by a completed read
  always_ff @(posedge pcie_clk) begin
    if (r_hs) begin
      rd_data <= rsp.rdata;
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      rd_done    <= 1'b0;
      resp_error <= 1'b0;
    end else begin
      rd_done <= r_hs;  // one-cycle pulse alongside new rd_data
      if (b_bad || r_bad) begin
        resp_error <= 1'b1;  // sticky until reset
      end
    end
  end

endmodule

`default_nettype wire

// File: dma_cfg_top.sv
`timescale 1ns/10ps
`default_nettype none

module dma_cfg_top (
  input  wire                          pcie_clk,
  input  wire                          pcie_aresetn,
  // axi-lite master toward the engine
  output dma_cfg_pkg::lite_wr_req_t    wr_req,
  output dma_cfg_pkg::lite_rd_req_t    rd_req,
  output wire                          bready,
  output wire                          rready,
  input  wire dma_cfg_pkg::lite_rsp_t    rsp,
  // host side
  input  wire dma_cfg_pkg::host_cmd_t    host_cmd,
  input  wire [31:0]                   host_awaddr,
  input  wire [31:0]                   host_wdata,
  input  wire [31:0]                   host_araddr,
  output wire                          boot_done,
  output wire [31:0]                   rd_data,
  output wire                          rd_done,
  output wire                          resp_error
);

  wire dma_cfg_pkg::lite_wr_req_t boot_wr;  // sequencer writes
  wire dma_cfg_pkg::lite_wr_req_t host_wr;  // host writes
  wire dma_cfg_pkg::lite_rd_req_t host_rd;  // host reads

  //////////////////////////////////////////////////////////////////////
  // request sources, side by side
  //////////////////////////////////////////////////////////////////////

  dma_boot_seq u_boot_seq (
    .pcie_clk     (pcie_clk),
    .pcie_aresetn (pcie_aresetn),
    .rsp          (rsp),
    .boot_wr      (boot_wr),
    .boot_done    (boot_done)
  );

  dma_host_access u_host_access (
    .pcie_clk     (pcie_clk),
    .pcie_aresetn (pcie_aresetn),
    .host_cmd     (host_cmd),
    .host_awaddr  (host_awaddr),
    .host_wdata   (host_wdata),
    .host_araddr  (host_araddr),
    .boot_done    (boot_done),   // holds host writes back
    .rsp          (rsp),
    .host_wr      (host_wr),
    .host_rd      (host_rd)
  );

  //////////////////////////////////////////////////////////////////////
  // merge onto the single axi-lite port
  //////////////////////////////////////////////////////////////////////

  dma_lite_merge u_lite_merge (
    .pcie_clk     (pcie_clk),
    .pcie_aresetn (pcie_aresetn),
    .boot_done    (boot_done),
    .boot_wr      (boot_wr),
    .host_wr      (host_wr),
    .host_rd      (host_rd),
    .rsp          (rsp),
    .wr_req       (wr_req),
    .rd_req       (rd_req),
    .bready       (bready),
    .rready       (rready),
    .rd_data      (rd_data),
    .rd_done      (rd_done),
    .resp_error   (resp_error)
  );

endmodule

`default_nettype wire

// File: tb_reg_target.sv
`timescale 1ns/10ps
`default_nettype none

module tb_reg_target (
  input  wire                            pcie_clk,
  input  wire                            pcie_aresetn,
  input  wire dma_cfg_pkg::lite_wr_req_t wr_req,
  input  wire dma_cfg_pkg::lite_rd_req_t rd_req,
  input  wire                            bready,
  input  wire                            rready,
  input  wire                            stall_en,  // random ready stalls on
  input  wire                            err_arm,   // next response is SLVERR
  output dma_cfg_pkg::lite_rsp_t         rsp,
  output logic                           wlog_valid,
  output dma_cfg_pkg::dma_reg_addr_u     wlog_addr,
  output logic [31:0]                    wlog_data
);

  logic [31:0] mem [0:65535];  // word per low address half
  logic [1:0] aw_cnt;  // cycles left before each ready returns
  logic [1:0] w_cnt;
  logic [1:0] ar_cnt;
  logic aw_got;  // address taken, data still to come
  dma_cfg_pkg::dma_reg_addr_u aw_addr_q;
  logic bvalid_q;
  logic [1:0] bresp_q;
  logic rvalid_q;
  logic [31:0] rdata_q;
  logic [1:0] rresp_q;
  logic err_pend;
  logic aw_hs;
  logic w_hs;
  logic ar_hs;
  integer seed;

  initial begin
    seed = 32'h5d79_07c1;
    for (int i = 0; i < 65536; i++) begin
      mem[i] = {16'(i) ^ 16'h5ac3, ~16'(i)};  // every word tells its own address
    end
  end

  always_comb begin
    rsp         = '0;
    rsp.awready = pcie_aresetn & (aw_cnt == 2'd0) & ~aw_got;
    rsp.wready  = pcie_aresetn & (w_cnt == 2'd0) & aw_got & ~bvalid_q;
    rsp.bvalid  = bvalid_q;
    rsp.bresp   = bresp_q;
    rsp.arready = pcie_aresetn & (ar_cnt == 2'd0) & ~rvalid_q;
    rsp.rvalid  = rvalid_q;
    rsp.rdata   = rdata_q;
    rsp.rresp   = rresp_q;
  end

  assign aw_hs = wr_req.awvalid & rsp.awready;
  assign w_hs  = wr_req.wvalid & rsp.wready;
  assign ar_hs = rd_req.arvalid & rsp.arready;

  // completed writes, seen by the testbench log
  assign wlog_valid = w_hs;
  assign wlog_addr  = aw_addr_q;
  assign wlog_data  = wr_req.wdata;

  ////////////////////////////////////////////////////////////////////
  // channel state
  ////////////////////////////////////////////////////////////////////

  always @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      aw_cnt   <= 2'd0;
      w_cnt    <= 2'd0;
      ar_cnt   <= 2'd0;
      aw_got   <= 1'b0;
      bvalid_q <= 1'b0;
      bresp_q  <= 2'b00;
      rvalid_q <= 1'b0;
      rresp_q  <= 2'b00;
      err_pend <= 1'b0;
    end else begin
      if (aw_hs) begin
        aw_addr_q <= wr_req.awaddr;
        aw_got    <= 1'b1;
        aw_cnt    <= stall_en ? 2'($unsigned($random(seed))) : 2'd0;
      end else if (aw_cnt != 2'd0) begin
        aw_cnt <= aw_cnt - 2'd1;
      end
      if (w_hs) begin
        mem[aw_addr_q.raw[15:0]] <= wr_req.wdata;
        aw_got   <= 1'b0;
        bvalid_q <= 1'b1;
        bresp_q  <= err_pend ? 2'b10 : 2'b00;  // SLVERR when armed
        w_cnt    <= stall_en ? 2'($unsigned($random(seed))) : 2'd0;
      end else if (w_cnt != 2'd0) begin
        w_cnt <= w_cnt - 2'd1;
      end
      if (bvalid_q && bready) begin
        bvalid_q <= 1'b0;
      end
      if (ar_hs) begin
        rvalid_q <= 1'b1;
        rdata_q  <= mem[rd_req.araddr.raw[15:0]];
        rresp_q  <= (err_pend && !w_hs) ? 2'b10 : 2'b00;  // b takes it first
        ar_cnt   <= stall_en ? 2'($unsigned($random(seed))) : 2'd0;
      end else if (ar_cnt != 2'd0) begin
        ar_cnt <= ar_cnt - 2'd1;
      end
      if (rvalid_q && rready) begin
        rvalid_q <= 1'b0;
      end
      if (err_arm) begin
        err_pend <= 1'b1;
      end else if (w_hs || ar_hs) begin
        err_pend <= 1'b0;  // one bad response only
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_dma_cfg_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_dma_cfg_top;

  logic pcie_clk;
  logic pcie_aresetn;
  dma_cfg_pkg::host_cmd_t host_cmd;
  logic [31:0] host_awaddr;
  logic [31:0] host_wdata;
  logic [31:0] host_araddr;
  logic stall_en;
  logic err_arm;
  dma_cfg_pkg::lite_wr_req_t wr_req;
  dma_cfg_pkg::lite_rd_req_t rd_req;
  dma_cfg_pkg::lite_rsp_t rsp;
  logic bready;
  logic rready;
  logic boot_done;
  logic [31:0] rd_data;
  logic rd_done;
  logic resp_error;
  logic wlog_valid;
  dma_cfg_pkg::dma_reg_addr_u wlog_addr;
  logic [31:0] wlog_data;

  dma_cfg_pkg::dma_reg_addr_u log_addr[$];  // writes seen by the target, in order
  logic [31:0] log_data[$];
  int errs;
  int n_pass;
  int n_fail;

  dma_cfg_top DUT (
    .pcie_clk     (pcie_clk),
    .pcie_aresetn (pcie_aresetn),
    .wr_req       (wr_req),
    .rd_req       (rd_req),
    .bready       (bready),
    .rready       (rready),
    .rsp          (rsp),
    .host_cmd     (host_cmd),
    .host_awaddr  (host_awaddr),
    .host_wdata   (host_wdata),
    .host_araddr  (host_araddr),
    .boot_done    (boot_done),
    .rd_data      (rd_data),
    .rd_done      (rd_done),
    .resp_error   (resp_error)
  );

  tb_reg_target u_target (
    .pcie_clk     (pcie_clk),
    .pcie_aresetn (pcie_aresetn),
    .wr_req       (wr_req),
    .rd_req       (rd_req),
    .bready       (bready),
    .rready       (rready),
    .stall_en     (stall_en),
    .err_arm      (err_arm),
    .rsp          (rsp),
    .wlog_valid   (wlog_valid),
    .wlog_addr    (wlog_addr),
    .wlog_data    (wlog_data)
  );

  always #20 pcie_clk = ~pcie_clk;  // 40 ns period

  always @(posedge pcie_clk) begin
    if (wlog_valid) begin
      log_addr.push_back(wlog_addr);
      log_data.push_back(wlog_data);
    end
  end

  ////////////////////////////////////////////////////////////////////
  // expected values and compares
  ////////////////////////////////////////////////////////////////////

  // step k hits channel (k/2+1) mod 4, c2h on odd steps, control reg 0x04
  function automatic dma_cfg_pkg::dma_reg_addr_u boot_addr(input int k);
    dma_cfg_pkg::dma_reg_addr_u a;
    a.raw = (32'(k % 2) << 12) | (32'(((k / 2) + 1) % 4) << 8) | 32'h04;
    return a;
  endfunction

  function automatic logic [31:0] fill_word(input logic [15:0] idx);
    return {idx ^ 16'h5ac3, ~idx};  // target contents before any write
  endfunction

  task automatic check_addr(input string name, input dma_cfg_pkg::dma_reg_addr_u got,
                            input dma_cfg_pkg::dma_reg_addr_u exp);
    if (got.raw !== exp.raw) begin
      $display("FAIL %s got %h expected %h", name, got.raw, exp.raw);
      errs++;
    end
  endtask

  task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      errs++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      errs++;
    end
  endtask

  task automatic end_test(input string name, input int errs_at_start);
    if (errs == errs_at_start) begin
      n_pass++;
      $display("%s: ok", name);
    end else begin
      n_fail++;
      $display("%s: %0d errors", name, errs - errs_at_start);
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // drivers and waits
  ////////////////////////////////////////////////////////////////////

  task automatic apply_reset(input logic stall);
    @(negedge pcie_clk);
    pcie_aresetn = 1'b0;
    stall_en     = stall;
    host_cmd     = '0;
    log_addr.delete();
    log_data.delete();
    repeat (4) @(negedge pcie_clk);
    pcie_aresetn = 1'b1;
  endtask

  task automatic host_write(input logic [31:0] a, input logic [31:0] d);
    @(negedge pcie_clk);
    host_awaddr = a;
    host_wdata  = d;
    host_cmd.wr = 1'b1;
    repeat (2) @(negedge pcie_clk);
    host_cmd.wr = 1'b0;
    @(negedge pcie_clk);
  endtask

  task automatic host_read(input logic [31:0] a, input logic [31:0] exp);
    int t;
    logic seen;
    @(negedge pcie_clk);
    host_araddr = a;
    host_cmd.rd = 1'b1;
    seen = 1'b0;
    t = 0;
    while (!seen && t < 400) begin
      @(negedge pcie_clk);
      t++;
      if (t == 2) host_cmd.rd = 1'b0;  // edge already sampled
      if (rd_done) begin
        seen = 1'b1;
        check_data("rd_data", rd_data, exp);
      end
    end
    host_cmd.rd = 1'b0;
    if (!seen) begin
      $display("timeout waiting for rd_done on the read of %h", a);
      errs++;
    end else begin
      @(negedge pcie_clk);
      check_flag("rd_done", rd_done, 1'b0);  // single cycle pulse
    end
  endtask

  // also checks boot_done against the number of logged writes
  task automatic wait_boot();
    int t;
    t = 0;
    while (!boot_done && t < 400) begin
      @(negedge pcie_clk);
      t++;
      if (!boot_done && log_addr.size() >= dma_cfg_pkg::boot_steps) begin
        $display("boot_done still low with %0d writes logged", log_addr.size());
        errs++;
      end
    end
    if (!boot_done) begin
      $display("timeout waiting for boot_done");
      errs++;
    end else begin
      check_data("writes at boot_done", 32'(log_addr.size()), 32'(dma_cfg_pkg::boot_steps));
    end
  endtask

  task automatic wait_log(input int n);
    int t;
    t = 0;
    while (log_addr.size() < n && t < 400) begin
      @(negedge pcie_clk);
      t++;
    end
    if (log_addr.size() < n) begin
      $display("timeout waiting for write %0d to reach the target", n);
      errs++;
    end
  endtask

  task automatic wait_resp_error();
    int t;
    t = 0;
    while (!resp_error && t < 400) begin
      @(negedge pcie_clk);
      t++;
    end
    if (!resp_error) begin
      $display("timeout waiting for resp_error after a SLVERR response");
      errs++;
    end
  endtask

  task automatic check_boot_log();
    if (log_addr.size() < dma_cfg_pkg::boot_steps) begin
      $display("only %0d boot writes reached the target", log_addr.size());
      errs++;
    end else begin
      for (int k = 0; k < dma_cfg_pkg::boot_steps; k++) begin
        check_addr($sformatf("boot awaddr step %0d", k), log_addr[k], boot_addr(k));
        check_data($sformatf("boot wdata step %0d", k), log_data[k], 32'h1);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////

  task automatic test_boot_order();
    int e0;
    e0 = errs;
    apply_reset(1'b0);
    wait_boot();
    repeat (10) @(negedge pcie_clk);
    check_flag("boot_done", boot_done, 1'b1);  // sticks once set
    check_data("write count", 32'(log_addr.size()), 32'd8);
    check_boot_log();
    end_test("boot order", e0);
  endtask

  task automatic test_host_during_boot();
    int e0;
    e0 = errs;
    apply_reset(1'b0);
    repeat (3) @(negedge pcie_clk);
    host_write(32'h0000_0e08, 32'h5a5a_0f0f);  // lands mid boot
    check_flag("boot_done", boot_done, 1'b0);
    wait_boot();
    check_boot_log();
    wait_log(dma_cfg_pkg::boot_steps + 1);  // held write goes out after boot
    if (log_addr.size() > dma_cfg_pkg::boot_steps) begin
      check_addr("held host awaddr", log_addr[8], 32'h0000_0e08);
      check_data("held host wdata", log_data[8], 32'h5a5a_0f0f);
    end
    end_test("host write during boot", e0);
  endtask

  task automatic test_host_write();
    int e0;
    int n0;
    e0 = errs;
    n0 = log_addr.size();
    host_write(32'h0000_2a10, 32'hc0de_5a17);
    wait_log(n0 + 1);
    repeat (8) @(negedge pcie_clk);
    if (log_addr.size() != n0 + 1) begin
      $display("expected exactly one new write, saw %0d", log_addr.size() - n0);
      errs++;
    end else begin
      check_addr("host awaddr", log_addr[n0], 32'h0000_2a10);
      check_data("host wdata", log_data[n0], 32'hc0de_5a17);
    end
    end_test("host write", e0);
  endtask

  task automatic test_host_read();
    int e0;
    e0 = errs;
    host_read(32'h0000_2a10, 32'hc0de_5a17);  // word from the host write
    host_read(32'h0000_1304, 32'h1);          // run bit from boot
    host_read(32'h0000_7ff8, fill_word(16'h7ff8));
    check_flag("resp_error", resp_error, 1'b0);
    end_test("host read", e0);
  endtask

  task automatic test_stall_boot();
    int e0;
    e0 = errs;
    apply_reset(1'b1);
    wait_boot();
    repeat (10) @(negedge pcie_clk);
    check_data("write count", 32'(log_addr.size()), 32'd8);
    check_boot_log();
    end_test("boot with stalls", e0);
  endtask

  task automatic test_slverr();
    int e0;
    int n0;
    e0 = errs;
    n0 = log_addr.size();
    check_flag("resp_error before write", resp_error, 1'b0);  // clean after the reset
    @(negedge pcie_clk);
    err_arm = 1'b1;
    @(negedge pcie_clk);
    err_arm = 1'b0;
    host_write(32'h0000_3c20, 32'h1234_abcd);
    wait_log(n0 + 1);
    wait_resp_error();
    host_read(32'h0000_2a10, 32'hc0de_5a17);  // clean read after the error
    check_flag("resp_error after read", resp_error, 1'b1);
    end_test("slverr sticky", e0);
  endtask

  initial begin
    pcie_clk     = 1'b0;
    pcie_aresetn = 1'b0;
    host_cmd     = '0;
    host_awaddr  = '0;
    host_wdata   = '0;
    host_araddr  = '0;
    stall_en     = 1'b0;
    err_arm      = 1'b0;
    errs         = 0;
    n_pass       = 0;
    n_fail       = 0;
    test_boot_order();
    test_host_during_boot();
    test_host_write();
    test_host_read();
    test_stall_boot();
    test_slverr();
    $display("tests passed %0d, tests failed %0d, check errors %0d", n_pass, n_fail, errs);
    if (errs == 0 && n_fail == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
dma_cfg_pkg.sv
dma_boot_seq.sv
dma_host_access.sv
dma_lite_merge.sv
dma_cfg_top.sv
tb_reg_target.sv
tb_dma_cfg_top.sv

// File: Makefile
# Verilator flow for the DMA config master testbench

VERILATOR   ?= verilator
TOP         ?= tb_dma_cfg_top
FILELIST    ?= tb.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
PASS_MSG    ?= Test completed successfully
LINT_FLAGS  ?= --lint-only -Wall --timing
BUILD_FLAGS ?= --binary --timing -Wno-fatal -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
